// File: cmd/cmd_logic.sv
////////////////////////////////////////
// Command engine: frame out, response in,
// CRC7, response timeout and busy tracking
////////////////////////////////////////

`timescale 1ns/1ps

module cmd_logic
  import sd_cmd_pkg::*;
#(
  parameter int unsigned NCR_MAX = 64
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      clk_en_p_i,
  input  logic      clk_en_n_i,
  input  logic      sd_cmd_i,
  output logic      sd_cmd_o,
  output logic      sd_cmd_oe_o,
  input  logic      sd_dat0_i,
  input  logic      cmd_valid_i,
  output logic      cmd_ready_o,
  input  cmd_idx_t  cmd_idx_i,
  input  cmd_arg_t  cmd_arg_i,
  input  rsp_type_e rsp_type_i,
  output logic      cmd_done_o,
  output logic      result_valid_o,
  output rsp_bits_t rsp_o,
  output logic      end_bit_err_o,
  output logic      crc_err_o,
  output logic      index_err_o,
  output logic      timeout_err_o,
  output logic      busy_o
);

  localparam int unsigned NCR_W = $clog2(NCR_MAX + 1);

  typedef enum logic [2:0] {IDLE, SEND, WAIT_RSP, RECV, BUSY} state_e;

  state_e           state_q;
  logic [47:0]      tx_q;
  logic [47:0]      tx_next;
  logic [127:0]     rx_q;
  logic [7:0]       bit_cnt_q;
  logic [NCR_W-1:0] ncr_cnt_q;
  logic [6:0]       crc_q;
  logic [6:0]       crc_nxt;
  logic             crc_in;
  cmd_idx_t         idx_q;
  rsp_type_e        rsp_type_q;
  logic             cmd_q, cmd_oe_q;
  logic             cmd_done_q, result_valid_q, timeout_q;
  logic             accept, tx_shift, rx_shift, start_seen;
  logic             long_rsp, has_rsp, rx_crc_en, last_bit;

  // x^7 + x^3 + 1, one bit per call
  function automatic logic [6:0] crc7_next(input logic [6:0] crc, input logic din);
    logic fb;
    fb = din ^ crc[6];
    return {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
  endfunction

  assign accept     = cmd_valid_i & cmd_ready_o;
  assign tx_shift   = (state_q == SEND) & clk_en_n_i & (bit_cnt_q < 8'd48);
  assign rx_shift   = (state_q == RECV) & clk_en_p_i;
  assign start_seen = (state_q == WAIT_RSP) & clk_en_p_i & ~sd_cmd_i;
  assign long_rsp   = (rsp_type_q == RSP_136);
  assign has_rsp    = (rsp_type_q != RSP_NONE);
  assign last_bit   = (bit_cnt_q == (long_rsp ? 8'd135 : 8'd47));

  // R2 skips the leading 8 bits and its own CRC field
  assign rx_crc_en = long_rsp ? (bit_cnt_q >= 8'd8 && bit_cnt_q < 8'd128)
                              : (bit_cnt_q < 8'd40);

  assign crc_in  = (state_q == SEND) ? tx_q[47] : sd_cmd_i;
  assign crc_nxt = crc7_next(crc_q, crc_in);

  // CRC is dropped into the frame right after the 40th bit
  always_comb begin
    tx_next = {tx_q[46:0], 1'b0};
    if (bit_cnt_q == 8'd39) begin
      tx_next[47:41] = crc_nxt;
    end
  end

  ////////////////////////////////////////
  // Shift registers
  always_ff @(posedge clk_i) begin
    if (accept) begin
      tx_q <= {1'b0, 1'b1, cmd_idx_i, cmd_arg_i, 7'b0, 1'b1};
    end else if (tx_shift) begin
      tx_q <= tx_next;
    end
    if (start_seen || rx_shift) begin
      rx_q <= {rx_q[126:0], sd_cmd_i};
    end
  end

  ////////////////////////////////////////
  // Control FSM
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q        <= IDLE;
      bit_cnt_q      <= '0;
      ncr_cnt_q      <= '0;
      crc_q          <= '0;
      idx_q          <= '0;
      rsp_type_q     <= RSP_NONE;
      cmd_q          <= 1'b1;
      cmd_oe_q       <= 1'b0;
      cmd_done_q     <= 1'b0;
      result_valid_q <= 1'b0;
      timeout_q      <= 1'b0;
    end else begin
      cmd_done_q     <= 1'b0;
      result_valid_q <= 1'b0;
      timeout_q      <= 1'b0;
      unique case (state_q)
        IDLE: begin
          if (accept) begin
            state_q    <= SEND;
            bit_cnt_q  <= '0;
            crc_q      <= '0;
            idx_q      <= cmd_idx_i;
            rsp_type_q <= rsp_type_i;
          end
        end
        SEND: begin
          if (tx_shift) begin
            cmd_q     <= tx_q[47];
            cmd_oe_q  <= 1'b1;
            bit_cnt_q <= bit_cnt_q + 8'd1;
            if (bit_cnt_q < 8'd40) begin
              crc_q <= crc_nxt;
            end
          end else if (clk_en_n_i) begin
            // End bit has been on the line for a full clock
            cmd_q      <= 1'b1;
            cmd_oe_q   <= 1'b0;
            cmd_done_q <= 1'b1;
            crc_q      <= '0;
            ncr_cnt_q  <= '0;
            if (has_rsp) begin
              state_q <= WAIT_RSP;
            end else begin
              result_valid_q <= 1'b1;
              state_q        <= IDLE;
            end
          end
        end
        WAIT_RSP: begin
          if (start_seen) begin
            state_q   <= RECV;
            bit_cnt_q <= 8'd1;
          end else if (clk_en_p_i) begin
            if (ncr_cnt_q == NCR_W'(NCR_MAX - 1)) begin
              timeout_q <= 1'b1;
              state_q   <= IDLE;
            end else begin
              ncr_cnt_q <= ncr_cnt_q + 1'b1;
            end
          end
        end
        RECV: begin
          if (rx_shift) begin
            bit_cnt_q <= bit_cnt_q + 8'd1;
            if (rx_crc_en) begin
              crc_q <= crc_nxt;
            end
            if (last_bit) begin
              result_valid_q <= 1'b1;
              state_q        <= (rsp_type_q == RSP_48_BUSY) ? BUSY : IDLE;
            end
          end
        end
        BUSY: begin
          if (clk_en_p_i && sd_dat0_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // No new command while a result or timeout is being reported
  assign cmd_ready_o = (state_q == IDLE) & ~result_valid_q & ~timeout_q;

  assign sd_cmd_o       = cmd_q;
  assign sd_cmd_oe_o    = cmd_oe_q;
  assign cmd_done_o     = cmd_done_q;
  assign result_valid_o = result_valid_q;
  assign timeout_err_o  = timeout_q;
  assign busy_o         = (state_q == BUSY);

  assign rsp_o         = long_rsp ? rx_q[127:8] : {88'b0, rx_q[39:8]};
  assign end_bit_err_o = has_rsp & ~rx_q[0];
  assign crc_err_o     = has_rsp & (crc_q != rx_q[7:1]);
  assign index_err_o   = has_rsp & ~long_rsp & (rx_q[45:40] != idx_q);

endmodule

// File: cmd/cmd_wrap.sv
////////////////////////////////////////
// Command queue with Auto CMD12 priority,
// response routing and error reporting
////////////////////////////////////////

`timescale 1ns/1ps

module cmd_wrap
  import sd_cmd_pkg::*;
#(
  parameter int unsigned NCR_MAX = 64
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       clk_en_p_i,
  input  logic       clk_en_n_i,
  input  logic       sd_cmd_i,
  output logic       sd_cmd_o,
  output logic       sd_cmd_oe_o,
  input  logic       sd_dat0_i,
  input  logic       cmd_write_i,
  input  cmd_idx_t   cmd_idx_i,
  input  cmd_arg_t   cmd_arg_i,
  input  rsp_type_e  rsp_type_i,
  input  logic       crc_chk_en_i,
  input  logic       idx_chk_en_i,
  input  logic [3:0] err_en_i,
  input  logic       cmd12_req_i,
  input  rsp_word_t  rsp_old3_i,
  output logic       cmd_done_o,
  output logic       rsp_done_o,
  output logic       busy_o,
  output rsp_word_t  rsp0_d_o,
  output rsp_word_t  rsp1_d_o,
  output rsp_word_t  rsp2_d_o,
  output rsp_word_t  rsp3_d_o,
  output logic       rsp_de_o,
  output logic [3:0] cmd_err_set_o,
  output logic [5:0] acmd12_err_set_o,
  output logic       inhibit_o
);

  logic      drv_queued_q, cmd12_queued_q, run_cmd12_q;
  rsp_type_e run_type_q;
  logic      cmd_queued, cmd_ready, submit;
  logic      result_valid, timeout_err;
  logic      end_bit_err, crc_err, index_err, any_err;
  rsp_bits_t rsp;
  cmd_idx_t  cur_idx;
  cmd_arg_t  cur_arg;
  rsp_type_e cur_type;

  assign cmd_queued = drv_queued_q | cmd12_queued_q;
  assign submit     = cmd_queued & cmd_ready;
  assign any_err    = end_bit_err | crc_err | index_err;

  // CMD12 goes first when both are pending
  assign cur_idx  = cmd12_queued_q ? CMD12_IDX : cmd_idx_i;
  assign cur_arg  = cmd12_queued_q ? '0 : cmd_arg_i;
  assign cur_type = cmd12_queued_q ? RSP_48_BUSY : rsp_type_i;

  ////////////////////////////////////////
  // Queue flags
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      drv_queued_q   <= 1'b0;
      cmd12_queued_q <= 1'b0;
      run_cmd12_q    <= 1'b0;
      run_type_q     <= RSP_NONE;
    end else begin
      if (cmd_write_i) begin
        drv_queued_q <= 1'b1;
      end
      if (cmd12_req_i) begin
        cmd12_queued_q <= 1'b1;
      end
      if (result_valid || timeout_err) begin
        run_cmd12_q <= 1'b0;
      end
      if (submit) begin
        run_cmd12_q <= cmd12_queued_q;
        run_type_q  <= cur_type;
        if (cmd12_queued_q) begin
          cmd12_queued_q <= 1'b0;
        end else begin
          drv_queued_q <= 1'b0;
        end
      end
      // A failed command flushes whatever is still waiting
      if ((result_valid && any_err) || timeout_err) begin
        drv_queued_q   <= 1'b0;
        cmd12_queued_q <= 1'b0;
      end
    end
  end

  assign inhibit_o = cmd_queued | ~cmd_ready;

  ////////////////////////////////////////
  // Response words
  always_comb begin
    rsp0_d_o = '0;
    rsp1_d_o = '0;
    rsp2_d_o = '0;
    rsp3_d_o = rsp_old3_i;
    if (run_cmd12_q) begin
      rsp3_d_o = rsp[31:0];
    end else if (run_type_q == RSP_136) begin
      rsp0_d_o       = rsp[31:0];
      rsp1_d_o       = rsp[63:32];
      rsp2_d_o       = rsp[95:64];
      // Top byte of word 3 is not part of R2
      rsp3_d_o[23:0] = rsp[119:96];
    end else begin
      rsp0_d_o = rsp[31:0];
    end
  end

  assign rsp_de_o = result_valid & (run_type_q != RSP_NONE);

  ////////////////////////////////////////
  // Error set pulses
  always_comb begin
    cmd_err_set_o    = '0;
    acmd12_err_set_o = '0;
    if (run_cmd12_q) begin
      acmd12_err_set_o[0] = result_valid & end_bit_err;
      acmd12_err_set_o[1] = result_valid & crc_err;
      acmd12_err_set_o[2] = result_valid & index_err;
      acmd12_err_set_o[3] = timeout_err;
    end else begin
      cmd_err_set_o[0] = result_valid & end_bit_err & err_en_i[0];
      cmd_err_set_o[1] = result_valid & crc_err & err_en_i[1] & crc_chk_en_i;
      cmd_err_set_o[2] = result_valid & index_err & err_en_i[2] & idx_chk_en_i;
      cmd_err_set_o[3] = timeout_err & err_en_i[3];
    end
    if ((result_valid && any_err) || timeout_err) begin
      // CMD12 was pending behind a failed driver command
      acmd12_err_set_o[4] = ~run_cmd12_q & cmd12_queued_q;
      // Driver command dropped after a failed CMD12
      acmd12_err_set_o[5] = run_cmd12_q & drv_queued_q;
    end
  end

  cmd_logic #(
    .NCR_MAX (NCR_MAX)
  ) cmd_logic_inst (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .clk_en_p_i     (clk_en_p_i),
    .clk_en_n_i     (clk_en_n_i),
    .sd_cmd_i       (sd_cmd_i),
    .sd_cmd_o       (sd_cmd_o),
    .sd_cmd_oe_o    (sd_cmd_oe_o),
    .sd_dat0_i      (sd_dat0_i),
    .cmd_valid_i    (cmd_queued),
    .cmd_ready_o    (cmd_ready),
    .cmd_idx_i      (cur_idx),
    .cmd_arg_i      (cur_arg),
    .rsp_type_i     (cur_type),
    .cmd_done_o     (cmd_done_o),
    .result_valid_o (result_valid),
    .rsp_o          (rsp),
    .end_bit_err_o  (end_bit_err),
    .crc_err_o      (crc_err),
    .index_err_o    (index_err),
    .timeout_err_o  (timeout_err),
    .busy_o         (busy_o)
  );

  assign rsp_done_o = result_valid;

endmodule

// File: common/sd_cmd_pkg.sv
////////////////////////////////////////
// Shared types for the SD command path
////////////////////////////////////////

package sd_cmd_pkg;

  // Command index as sent in the frame
  typedef logic [5:0] cmd_idx_t;

  // Command argument
  typedef logic [31:0] cmd_arg_t;

  // One 32-bit response register word
  typedef logic [31:0] rsp_word_t;

  // Response content without start, transmission, CRC and end bits.
  // For a 48-bit response only bits 31:0 carry the card status
  typedef logic [119:0] rsp_bits_t;

  // Divider half-period in clk_i cycles
  typedef logic [7:0] clk_div_t;

  // Response type select, same encoding as the host register field
  typedef enum logic [1:0] {
    RSP_NONE    = 2'b00,
    RSP_136     = 2'b01,
    RSP_48      = 2'b10,
    RSP_48_BUSY = 2'b11
  } rsp_type_e;

  // STOP_TRANSMISSION
  localparam cmd_idx_t CMD12_IDX = cmd_idx_t'(12);

endpackage

// File: design/sd_clk_div.sv
////////////////////////////////////////
// SD clock divider with edge strobes
////////////////////////////////////////

`timescale 1ns/1ps

module sd_clk_div
  import sd_cmd_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  clk_div_t div_i,
  output logic     sd_clk_o,
  output logic     clk_en_p_o,
  output logic     clk_en_n_o
);

  clk_div_t limit;
  clk_div_t cnt_q;
  logic     sd_clk_q;
  logic     started_q;
  logic     tick;

  // Divide-by-1 is not supported
  assign limit = (div_i < clk_div_t'(2)) ? clk_div_t'(2) : div_i;
  assign tick  = (cnt_q >= limit - clk_div_t'(1));

  // First half period after reset keeps the clock low
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q     <= '0;
      sd_clk_q  <= 1'b0;
      started_q <= 1'b0;
    end else if (tick) begin
      cnt_q     <= '0;
      started_q <= 1'b1;
      if (started_q) begin
        sd_clk_q <= ~sd_clk_q;
      end
    end else begin
      cnt_q <= cnt_q + clk_div_t'(1);
    end
  end

  assign sd_clk_o   = sd_clk_q;
  // High in the cycle before the toggle edge
  assign clk_en_p_o = started_q & tick & ~sd_clk_q;
  assign clk_en_n_o = started_q & tick & sd_clk_q;

endmodule

// File: design/sd_cmd_top.sv
////////////////////////////////////////
// SD command path top level
////////////////////////////////////////

`timescale 1ns/1ps

module sd_cmd_top
  import sd_cmd_pkg::*;
#(
  parameter int unsigned NCR_MAX = 64
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  clk_div_t   div_i,
  output logic       sd_clk_o,
  input  logic       sd_cmd_i,
  output logic       sd_cmd_o,
  output logic       sd_cmd_oe_o,
  input  logic       sd_dat0_i,
  input  logic       cmd_write_i,
  input  cmd_idx_t   cmd_idx_i,
  input  cmd_arg_t   cmd_arg_i,
  input  rsp_type_e  rsp_type_i,
  input  logic       crc_chk_en_i,
  input  logic       idx_chk_en_i,
  input  logic [3:0] err_en_i,
  input  logic       cmd12_req_i,
  input  logic [9:0] err_clr_i,
  output logic       cmd_done_o,
  output logic       rsp_done_o,
  output logic       busy_o,
  output logic       inhibit_o,
  output rsp_word_t  rsp0_o,
  output rsp_word_t  rsp1_o,
  output rsp_word_t  rsp2_o,
  output rsp_word_t  rsp3_o,
  output logic [9:0] err_status_o
);

  logic       clk_en_p, clk_en_n;
  rsp_word_t  rsp0_d, rsp1_d, rsp2_d, rsp3_d;
  logic       rsp_de;
  logic [3:0] cmd_err_set;
  logic [5:0] acmd12_err_set;

  sd_clk_div sd_clk_div_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .div_i      (div_i),
    .sd_clk_o   (sd_clk_o),
    .clk_en_p_o (clk_en_p),
    .clk_en_n_o (clk_en_n)
  );

  cmd_wrap #(
    .NCR_MAX (NCR_MAX)
  ) cmd_wrap_inst (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .clk_en_p_i       (clk_en_p),
    .clk_en_n_i       (clk_en_n),
    .sd_cmd_i         (sd_cmd_i),
    .sd_cmd_o         (sd_cmd_o),
    .sd_cmd_oe_o      (sd_cmd_oe_o),
    .sd_dat0_i        (sd_dat0_i),
    .cmd_write_i      (cmd_write_i),
    .cmd_idx_i        (cmd_idx_i),
    .cmd_arg_i        (cmd_arg_i),
    .rsp_type_i       (rsp_type_i),
    .crc_chk_en_i     (crc_chk_en_i),
    .idx_chk_en_i     (idx_chk_en_i),
    .err_en_i         (err_en_i),
    .cmd12_req_i      (cmd12_req_i),
    .rsp_old3_i       (rsp3_o),
    .cmd_done_o       (cmd_done_o),
    .rsp_done_o       (rsp_done_o),
    .busy_o           (busy_o),
    .rsp0_d_o         (rsp0_d),
    .rsp1_d_o         (rsp1_d),
    .rsp2_d_o         (rsp2_d),
    .rsp3_d_o         (rsp3_d),
    .rsp_de_o         (rsp_de),
    .cmd_err_set_o    (cmd_err_set),
    .acmd12_err_set_o (acmd12_err_set),
    .inhibit_o        (inhibit_o)
  );

  sd_status_regs sd_status_regs_inst (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .rsp0_d_i         (rsp0_d),
    .rsp1_d_i         (rsp1_d),
    .rsp2_d_i         (rsp2_d),
    .rsp3_d_i         (rsp3_d),
    .rsp_de_i         (rsp_de),
    .cmd_err_set_i    (cmd_err_set),
    .acmd12_err_set_i (acmd12_err_set),
    .err_clr_i        (err_clr_i),
    .rsp0_o           (rsp0_o),
    .rsp1_o           (rsp1_o),
    .rsp2_o           (rsp2_o),
    .rsp3_o           (rsp3_o),
    .err_status_o     (err_status_o)
  );

endmodule

// File: design/sd_status_regs.sv
////////////////////////////////////////
// Response registers and sticky errors
////////////////////////////////////////

`timescale 1ns/1ps

module sd_status_regs
  import sd_cmd_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  rsp_word_t  rsp0_d_i,
  input  rsp_word_t  rsp1_d_i,
  input  rsp_word_t  rsp2_d_i,
  input  rsp_word_t  rsp3_d_i,
  input  logic       rsp_de_i,
  input  logic [3:0] cmd_err_set_i,
  input  logic [5:0] acmd12_err_set_i,
  input  logic [9:0] err_clr_i,
  output rsp_word_t  rsp0_o,
  output rsp_word_t  rsp1_o,
  output rsp_word_t  rsp2_o,
  output rsp_word_t  rsp3_o,
  output logic [9:0] err_status_o
);

  rsp_word_t  rsp0_q, rsp1_q, rsp2_q, rsp3_q;
  logic [9:0] err_q;
  logic [9:0] err_set;

  // Auto CMD12 bits sit above the command bits
  assign err_set = {acmd12_err_set_i, cmd_err_set_i};

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp0_q <= '0;
      rsp1_q <= '0;
      rsp2_q <= '0;
      rsp3_q <= '0;
      err_q  <= '0;
    end else begin
      if (rsp_de_i) begin
        rsp0_q <= rsp0_d_i;
        rsp1_q <= rsp1_d_i;
        rsp2_q <= rsp2_d_i;
        rsp3_q <= rsp3_d_i;
      end
      // Write one to clear, a new event wins
      err_q <= (err_q & ~err_clr_i) | err_set;
    end
  end

  assign rsp0_o       = rsp0_q;
  assign rsp1_o       = rsp1_q;
  assign rsp2_o       = rsp2_q;
  assign rsp3_o       = rsp3_q;
  assign err_status_o = err_q;

endmodule

// File: run.sh
#!/bin/sh
# Build and run the SD command path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_sd_cmd -f src.f \
  --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log || ! grep -q "TEST PASSED" sim.log; then
  exit 1
fi
exit 0

// File: src.f
common/sd_cmd_pkg.sv
design/sd_clk_div.sv
cmd/cmd_logic.sv
cmd/cmd_wrap.sv
design/sd_status_regs.sv
design/sd_cmd_top.sv
tests/sd_card_model.sv
tests/tb_sd_cmd.sv

// File: tests/sd_card_model.sv
////////////////////////////////////////
// Behavioural SD card for the CMD line:
// frame capture, responses and DAT0 busy
////////////////////////////////////////

`timescale 1ns/1ps

module sd_card_model (
  input  logic         sd_clk_i,
  input  logic         cmd_i,
  output logic         cmd_o,
  output logic         dat0_o,
  // 0 silent, 1 48-bit response, 2 136-bit response
  input  logic [1:0]   rsp_mode_i,
  input  logic [119:0] payload_i,
  input  logic         bad_crc_i,
  input  logic         bad_idx_i,
  input  logic         bad_end_i,
  input  logic [7:0]   busy_clks_i,
  output logic [47:0]  frame_o,
  output int           frame_cnt_o
);

  logic [47:0]  frame;
  logic [135:0] rsp;
  logic [6:0]   crc;
  logic [5:0]   idx;
  logic [7:0]   busy_n;
  int           nbits;
  int           i;

  // Serial CRC7, MSB first over the low n bits of d
  function automatic logic [6:0] crc7_of(input logic [119:0] d, input int n);
    logic [6:0] c;
    logic       fb;
    int         k;
    c = '0;
    for (k = n - 1; k >= 0; k--) begin
      fb = d[k] ^ c[6];
      c  = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    end
    return c;
  endfunction

  // Config is taken when the command frame has ended
  task automatic build_response();
    busy_n = busy_clks_i;
    if (rsp_mode_i == 2'd2) begin
      nbits = 136;
      crc   = crc7_of(payload_i, 120);
      rsp   = {2'b00, 6'b111111, payload_i, crc ^ {6'b0, bad_crc_i}, ~bad_end_i};
    end else begin
      nbits = 48;
      idx   = frame[45:40] ^ {5'b0, bad_idx_i};
      crc   = crc7_of({80'b0, 2'b00, idx, payload_i[31:0]}, 40);
      rsp   = {88'b0, 2'b00, idx, payload_i[31:0], crc ^ {6'b0, bad_crc_i}, ~bad_end_i};
    end
  endtask

  task automatic send_response();
    // Two falling edges of gap after the end bit
    repeat (2) @(negedge sd_clk_i);
    for (i = nbits - 1; i >= 0; i--) begin
      cmd_o = rsp[i];
      @(negedge sd_clk_i);
    end
    cmd_o = 1'b1;
    if (busy_n > 8'd0) begin
      dat0_o = 1'b0;
      repeat (busy_n) @(negedge sd_clk_i);
      dat0_o = 1'b1;
    end
  endtask

  initial begin
    cmd_o       = 1'b1;
    dat0_o      = 1'b1;
    frame_o     = '0;
    frame_cnt_o = 0;
    forever begin
      @(posedge sd_clk_i);
      if (cmd_i === 1'b0) begin
        frame = '0;
        for (i = 1; i < 48; i++) begin
          @(posedge sd_clk_i);
          frame = {frame[46:0], cmd_i};
        end
        frame_o     = frame;
        frame_cnt_o = frame_cnt_o + 1;
        if (rsp_mode_i != 2'd0) begin
          build_response();
          send_response();
        end
      end
    end
  end

endmodule

// File: tests/tb_sd_cmd.sv
////////////////////////////////////////
// Testbench for the SD command path:
// directed tests, watchdog and summary
////////////////////////////////////////

`timescale 1ns/1ps

module tb_sd_cmd
  import sd_cmd_pkg::*;
();

  localparam int LIMIT     = 3000;
  // Roughly 30 commands of up to 1000 clk_i cycles each, times two
  localparam int N_CMDS    = 30;
  localparam int CMD_CLKS  = 1000;
  localparam int WDOG_NS   = N_CMDS * CMD_CLKS * 20 * 2;

  logic         clk_i, rst_n_i;
  clk_div_t     div;
  logic         sd_clk, sd_cmd_o, sd_cmd_oe, sd_line, dat0, card_cmd;
  logic         cmd_write, cmd12_req, crc_chk_en, idx_chk_en;
  cmd_idx_t     cmd_idx;
  cmd_arg_t     cmd_arg;
  rsp_type_e    rsp_type;
  logic [3:0]   err_en;
  logic [9:0]   err_clr, err_status;
  logic         cmd_done, rsp_done, busy, inhibit;
  rsp_word_t    rsp0, rsp1, rsp2, rsp3;
  logic [1:0]   rsp_mode;
  logic [119:0] payload;
  logic         bad_crc, bad_idx, bad_end;
  logic [7:0]   busy_clks;
  logic [47:0]  frame;
  int           frame_cnt;
  int           errors;
  int           checks;
  integer       seed;
  rsp_word_t    last_rsp3;

  // Host output wins over the card while enabled
  assign sd_line = sd_cmd_oe ? sd_cmd_o : card_cmd;

  sd_cmd_top #(.NCR_MAX(64)) sd_cmd_top_inst (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .div_i(div),
    .sd_clk_o(sd_clk), .sd_cmd_i(sd_line), .sd_cmd_o(sd_cmd_o),
    .sd_cmd_oe_o(sd_cmd_oe), .sd_dat0_i(dat0),
    .cmd_write_i(cmd_write), .cmd_idx_i(cmd_idx), .cmd_arg_i(cmd_arg),
    .rsp_type_i(rsp_type), .crc_chk_en_i(crc_chk_en), .idx_chk_en_i(idx_chk_en),
    .err_en_i(err_en), .cmd12_req_i(cmd12_req), .err_clr_i(err_clr),
    .cmd_done_o(cmd_done), .rsp_done_o(rsp_done), .busy_o(busy),
    .inhibit_o(inhibit), .rsp0_o(rsp0), .rsp1_o(rsp1), .rsp2_o(rsp2),
    .rsp3_o(rsp3), .err_status_o(err_status)
  );

  sd_card_model card_inst (
    .sd_clk_i(sd_clk), .cmd_i(sd_line), .cmd_o(card_cmd), .dat0_o(dat0),
    .rsp_mode_i(rsp_mode), .payload_i(payload), .bad_crc_i(bad_crc),
    .bad_idx_i(bad_idx), .bad_end_i(bad_end), .busy_clks_i(busy_clks),
    .frame_o(frame), .frame_cnt_o(frame_cnt)
  );

  always #10 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Helpers

  // CRC7 x^7 + x^3 + 1 over the first 40 frame bits
  function automatic logic [6:0] crc7(input logic [39:0] d);
    logic [6:0] r;
    int         k;
    r = 7'h0;
    for (k = 39; k >= 0; k--) begin
      r = {r[5:0], 1'b0} ^ ((r[6] ^ d[k]) ? 7'h09 : 7'h00);
    end
    return r;
  endfunction

  task automatic step();
    @(posedge clk_i);
    #2;
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic report(input string what);
    errors++;
    $display("ERROR: %s", what);
  endtask

  task automatic card_setup(input logic [1:0] mode, input logic [119:0] pl,
                            input bit crc, input bit idx, input bit endb,
                            input logic [7:0] busy_n);
    rsp_mode  = mode;
    payload   = pl;
    bad_crc   = crc;
    bad_idx   = idx;
    bad_end   = endb;
    busy_clks = busy_n;
  endtask

  task automatic issue(input cmd_idx_t idx, input cmd_arg_t arg, input rsp_type_e rt,
                       input bit wr, input bit c12);
    cmd_idx   = idx;
    cmd_arg   = arg;
    rsp_type  = rt;
    cmd_write = wr;
    cmd12_req = c12;
    step();
    cmd_write = 1'b0;
    cmd12_req = 1'b0;
  endtask

  // Returns in the cycle where cmd_done_o is high
  task automatic wait_cmd_done();
    int n;
    n = 0;
    while (cmd_done !== 1'b1 && n < LIMIT) begin
      step();
      n++;
    end
    if (n == LIMIT) report("cmd_done_o did not pulse within the cycle limit");
  endtask

  // Returns one cycle after rsp_done_o so the status registers are updated
  task automatic wait_rsp_done();
    int n;
    n = 0;
    while (rsp_done !== 1'b1 && n < LIMIT) begin
      step();
      n++;
    end
    if (n == LIMIT) report("rsp_done_o did not pulse within the cycle limit");
    step();
  endtask

  task automatic wait_status(input int b);
    int n;
    n = 0;
    while (err_status[b] !== 1'b1 && n < LIMIT) begin
      step();
      n++;
    end
    if (n == LIMIT) report("expected error status bit was never set");
  endtask

  task automatic wait_frames(input int cnt);
    int n;
    n = 0;
    while (frame_cnt < cnt && n < LIMIT) begin
      step();
      n++;
    end
    if (n == LIMIT) report("card captured no command frame in time");
  endtask

  task automatic clear_errors();
    err_clr = 10'h3ff;
    step();
    err_clr = 10'h000;
    step();
    check("err_status_o", 64'(err_status), 64'h0);
  endtask

  ////////////////////////////////////////
  // Tests

  task automatic test_reset_values();
    check("sd_cmd_oe_o", 64'(sd_cmd_oe), 64'h0);
    check("sd_cmd_o", 64'(sd_cmd_o), 64'h1);
    check("cmd_done_o", 64'(cmd_done), 64'h0);
    check("rsp_done_o", 64'(rsp_done), 64'h0);
    check("busy_o", 64'(busy), 64'h0);
    check("inhibit_o", 64'(inhibit), 64'h0);
    check("err_status_o", 64'(err_status), 64'h0);
    check("rsp0_o", 64'(rsp0), 64'h0);
    check("rsp1_o", 64'(rsp1), 64'h0);
    check("rsp2_o", 64'(rsp2), 64'h0);
    check("rsp3_o", 64'(rsp3), 64'h0);
  endtask

  task automatic test_frame();
    cmd_arg_t    arg;
    cmd_idx_t    idx;
    logic [47:0] exp;
    int          cnt;
    int          k;
    for (k = 0; k < 4; k++) begin
      arg = $random(seed);
      idx = cmd_idx_t'(17 + k * 3);
      card_setup(2'd1, 120'(arg ^ 32'h0000_0900), 0, 0, 0, 8'd0);
      cnt = frame_cnt;
      issue(idx, arg, RSP_48, 1'b1, 1'b0);
      wait_cmd_done();
      // Whole frame reached the card and the line is released
      check("frame count at cmd_done_o", 64'(frame_cnt), 64'(cnt + 1));
      check("sd_cmd_oe_o", 64'(sd_cmd_oe), 64'h0);
      step();
      check("cmd_done_o", 64'(cmd_done), 64'h0);
      wait_rsp_done();
      exp = {2'b01, idx, arg, crc7({2'b01, idx, arg}), 1'b1};
      check("frame", 64'(frame), 64'(exp));
      check("frame count", 64'(frame_cnt), 64'(cnt + 1));
      check("err_status_o", 64'(err_status), 64'h0);
    end
  endtask

  task automatic test_auto_cmd12();
    rsp_word_t status;
    int        cnt;
    status = $random(seed);
    card_setup(2'd1, 120'(status), 0, 0, 0, 8'd0);
    cnt = frame_cnt;
    issue(6'd25, $random(seed), RSP_48, 1'b1, 1'b1);
    wait_frames(cnt + 1);
    check("CMD12 frame index and argument", 64'(frame[45:8]), 64'({CMD12_IDX, 32'h0}));
    wait_frames(cnt + 2);
    check("driver frame index", 64'(frame[45:40]), 64'd25);
    wait_rsp_done();
    check("rsp3_o", 64'(rsp3), 64'(status));
    check("rsp0_o", 64'(rsp0), 64'(status));
    // CMD12 alone with a corrupted CRC
    status = $random(seed);
    card_setup(2'd1, 120'(status), 1, 0, 0, 8'd0);
    issue(6'd25, '0, RSP_48, 1'b0, 1'b1);
    wait_rsp_done();
    check("err_status_o", 64'(err_status), 64'h020);
    check("rsp3_o", 64'(rsp3), 64'(status));
    last_rsp3 = status;
    clear_errors();
  endtask

  task automatic test_responses();
    rsp_word_t    w0, w1, w2, w3;
    logic [119:0] pl;
    w0 = $random(seed);
    card_setup(2'd1, 120'(w0), 0, 0, 0, 8'd0);
    issue(6'd13, $random(seed), RSP_48, 1'b1, 1'b0);
    wait_rsp_done();
    check("rsp0_o", 64'(rsp0), 64'(w0));
    w0 = $random(seed);
    w1 = $random(seed);
    w2 = $random(seed);
    w3 = $random(seed);
    pl = {w3[23:0], w2, w1, w0};
    card_setup(2'd2, pl, 0, 0, 0, 8'd0);
    issue(6'd2, '0, RSP_136, 1'b1, 1'b0);
    wait_rsp_done();
    check("rsp0_o", 64'(rsp0), 64'(w0));
    check("rsp1_o", 64'(rsp1), 64'(w1));
    check("rsp2_o", 64'(rsp2), 64'(w2));
    check("rsp3_o", 64'(rsp3), 64'({last_rsp3[31:24], w3[23:0]}));
    check("err_status_o", 64'(err_status), 64'h0);
  endtask

  task automatic err_case(input string name, input bit crc, input bit idx,
                          input bit endb, input bit enabled, input int b);
    logic [9:0] exp;
    card_setup(2'd1, 120'(32'h0000_0900), crc, idx, endb, 8'd0);
    err_en     = (enabled || b != 0) ? 4'hf : 4'he;
    crc_chk_en = enabled | ~crc;
    idx_chk_en = enabled | ~idx;
    issue(6'd13, $random(seed), RSP_48, 1'b1, 1'b0);
    wait_rsp_done();
    exp = enabled ? (10'h1 << b) : 10'h0;
    check($sformatf("err_status_o (%s)", name), 64'(err_status), 64'(exp));
    // Sticky until cleared
    repeat (20) step();
    check($sformatf("err_status_o (%s)", name), 64'(err_status), 64'(exp));
    clear_errors();
    err_en     = 4'hf;
    crc_chk_en = 1'b1;
    idx_chk_en = 1'b1;
  endtask

  task automatic test_errors();
    err_case("end bit error", 0, 0, 1, 1, 0);
    err_case("end bit error disabled", 0, 0, 1, 0, 0);
    err_case("CRC error", 1, 0, 0, 1, 1);
    err_case("CRC error disabled", 1, 0, 0, 0, 1);
    err_case("index error", 0, 1, 0, 1, 2);
    err_case("index error disabled", 0, 1, 0, 0, 2);
    card_setup(2'd0, '0, 0, 0, 0, 8'd0);
    issue(6'd13, $random(seed), RSP_48, 1'b1, 1'b0);
    wait_status(3);
    repeat (20) step();
    check("err_status_o", 64'(err_status), 64'h008);
    clear_errors();
  endtask

  task automatic test_busy();
    int cnt;
    int n;
    card_setup(2'd1, 120'(32'h0000_0b00), 0, 0, 0, 8'd20);
    issue(6'd7, $random(seed), RSP_48_BUSY, 1'b1, 1'b0);
    wait_rsp_done();
    cnt = frame_cnt;
    card_setup(2'd1, 120'(32'h0000_0900), 0, 0, 0, 8'd0);
    issue(6'd13, $random(seed), RSP_48, 1'b1, 1'b0);
    n = 0;
    while (busy === 1'b1 && n < LIMIT) begin
      if (inhibit !== 1'b1) report("inhibit_o went low while the card was busy");
      if (frame_cnt != cnt || sd_cmd_oe !== 1'b0) report("a frame started during busy");
      step();
      n++;
    end
    if (n == LIMIT) report("busy_o stayed high after the card released DAT0");
    if (dat0 !== 1'b1) report("busy_o ended before the card released DAT0");
    wait_rsp_done();
    check("rsp0_o", 64'(rsp0), 64'h900);
  endtask

  task automatic test_abort();
    int cnt;
    // Silent card during CMD12 with a driver command queued
    card_setup(2'd0, '0, 0, 0, 0, 8'd0);
    cnt = frame_cnt;
    issue(6'd18, $random(seed), RSP_48, 1'b1, 1'b1);
    wait_status(7);
    repeat (600) step();
    check("err_status_o", 64'(err_status), 64'h280);
    check("frame count", 64'(frame_cnt), 64'(cnt + 1));
    clear_errors();
    // Driver command fails while CMD12 waits
    card_setup(2'd1, 120'(32'h0000_0900), 1, 0, 0, 8'd0);
    cnt = frame_cnt;
    issue(6'd18, $random(seed), RSP_48, 1'b1, 1'b0);
    wait_frames(cnt + 1);
    issue(6'd18, cmd_arg, RSP_48, 1'b0, 1'b1);
    wait_rsp_done();
    repeat (600) step();
    check("err_status_o", 64'(err_status), 64'h102);
    check("frame count", 64'(frame_cnt), 64'(cnt + 1));
    clear_errors();
  endtask

  ////////////////////////////////////////
  // Main sequence and watchdog

  initial begin
    seed       = 32'hbd12_c6c8;
    errors     = 0;
    checks     = 0;
    last_rsp3  = '0;
    clk_i      = 1'b0;
    rst_n_i    = 1'b0;
    div        = clk_div_t'(2);
    cmd_write  = 1'b0;
    cmd12_req  = 1'b0;
    cmd_idx    = '0;
    cmd_arg    = '0;
    rsp_type   = RSP_NONE;
    crc_chk_en = 1'b1;
    idx_chk_en = 1'b1;
    err_en     = 4'hf;
    err_clr    = '0;
    card_setup(2'd1, '0, 0, 0, 0, 8'd0);
    repeat (16) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    step();
    test_reset_values();
    test_frame();
    test_auto_cmd12();
    test_responses();
    test_errors();
    test_busy();
    test_abort();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    #(WDOG_NS * 1ns);
    $display("Watchdog expired before the tests ended, %0d errors so far", errors);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule
